//--- files.f
hw/dma_attach_pkg.sv
hw/axis_skid_buffer.sv
hw/h2c_queue_arbiter.sv
hw/c2h_port_steer.sv
hw/dma_attach_top.sv
dv/tb_dma_attach.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the DMA attachment testbench
# the run passes only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dma_attach \
  -f files.f -o tb_dma_attach_sim \
  && ./obj_dir/tb_dma_attach_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log 2>/dev/null && exit 0 || exit 1

//--- dv/tb_dma_attach.sv
/*
  Testbench for the DMA attachment. Drives both host queues and nf_rx with
  xorshift packets and random ready on every output. Scoreboards are filled
  when a packet is scheduled, so nf_tx order assumes the queue-0-first round
  robin that follows the queue-1-only tagging phase.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_dma_attach import dma_attach_pkg::*; ();

  logic      axis_aclk;
  logic      axis_rst;
  h2c_beat_t h2c_0_beat;
  logic      h2c_0_valid;
  logic      h2c_0_ready;
  h2c_beat_t h2c_1_beat;
  logic      h2c_1_valid;
  logic      h2c_1_ready;
  nf_beat_t  nf_tx_beat;
  logic      nf_tx_valid;
  logic      nf_tx_ready;
  nf_beat_t  nf_rx_beat;
  logic      nf_rx_valid;
  logic      nf_rx_ready;
  c2h_beat_t c2h_0_beat;
  logic      c2h_0_valid;
  logic      c2h_0_ready;
  c2h_beat_t c2h_1_beat;
  logic      c2h_1_valid;
  logic      c2h_1_ready;

  // stimulus waiting to be driven, and beats each output still owes
  h2c_beat_t h0_stim [$];
  h2c_beat_t h1_stim [$];
  nf_beat_t  rx_stim [$];
  nf_beat_t  exp_tx [$];
  c2h_beat_t exp_c2h0 [$];
  c2h_beat_t exp_c2h1 [$];

  nf_beat_t    exp_tx_beat;
  c2h_beat_t   exp_c2h0_beat;
  c2h_beat_t   exp_c2h1_beat;
  logic [31:0] rng = 32'h92f1;
  logic [31:0] rdy_rng = 32'h92f1;
  logic        rst_seen = 1'b0;
  int          errors = 0;
  int          sched_beats = 0;
  string       test_name = "after_reset";
  port_mask_t  dst_list [5] = '{8'h02, 8'h08, 8'h0a, 8'h00, 8'hf5};

  dma_attach_top u_dma_attach_top (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic int rand_beats();
    return 1 + int'(draw_word() % 32'd4);
  endfunction

  // host packet plus the tagged beats expected on nf_tx
  task automatic queue_h2c_packet(input logic from_q1, input int nbeats);
    h2c_beat_t hb;
    nf_beat_t  nb;
    int        pad;
    pkt_len_t  len;
    pad = int'(draw_word() % 32'd8);
    len = pkt_len_t'(nbeats * 8 - pad);
    for (int i = 0; i < nbeats; i++) begin
      hb.tdata = {draw_word(), draw_word()};
      hb.tkeep = (i == nbeats - 1) ? tkeep_t'(8'hff >> pad) : 8'hff;
      hb.tlast = (i == nbeats - 1);
      hb.size  = len;
      nb.tdata = hb.tdata;
      nb.tkeep = hb.tkeep;
      nb.tlast = hb.tlast;
      nb.tuser.pkt_len  = len;
      nb.tuser.src_port = from_q1 ? 8'h08 : 8'h02;
      nb.tuser.dst_port = 8'h00;
      nb.tuser.reserved = '0;
      if (from_q1) begin
        h1_stim.push_back(hb);
      end else begin
        h0_stim.push_back(hb);
      end
      exp_tx.push_back(nb);
    end
    sched_beats += nbeats;
  endtask

  // later beats carry a random tuser that steering must ignore
  task automatic queue_rx_packet(input port_mask_t dst, input int nbeats);
    nf_beat_t   nb;
    c2h_beat_t  cb;
    pkt_len_t   len;
    port_mask_t src;
    len = '0;
    src = '0;
    for (int i = 0; i < nbeats; i++) begin
      nb.tdata = {draw_word(), draw_word()};
      nb.tkeep = tkeep_t'(draw_word());
      nb.tlast = (i == nbeats - 1);
      nb.tuser = {draw_word(), draw_word(), draw_word(), draw_word()};
      if (i == 0) begin
        nb.tuser.dst_port = dst;
        len = nb.tuser.pkt_len;
        src = nb.tuser.src_port;
      end
      rx_stim.push_back(nb);
      cb.tdata = nb.tdata;
      cb.tkeep = nb.tkeep;
      cb.tlast = nb.tlast;
      cb.size  = len;
      cb.src   = {8'h00, src};
      if (dst[1]) begin
        cb.dst = 16'h1;
        exp_c2h0.push_back(cb);
      end
      if (dst[3]) begin
        cb.dst = 16'h2;
        exp_c2h1.push_back(cb);
      end
    end
    sched_beats += nbeats;
  endtask

  task automatic wait_drain();
    while (h0_stim.size() != 0 || h1_stim.size() != 0 || rx_stim.size() != 0 ||
           exp_tx.size() != 0 || exp_c2h0.size() != 0 || exp_c2h1.size() != 0) begin
      @(posedge axis_aclk);
    end
    repeat (4) @(posedge axis_aclk);
  endtask

  initial begin : clock_gen
    axis_aclk = 1'b0;
    forever #2 axis_aclk = ~axis_aclk;
  end

  // each source samples the handshake at the edge and moves on 1 ns later
  initial begin : drive_h2c_0
    logic fire;
    h2c_0_valid = 1'b0;
    h2c_0_beat  = '0;
    forever begin
      @(posedge axis_aclk);
      fire = h2c_0_valid && h2c_0_ready;
      #1;
      if (fire) begin
        void'(h0_stim.pop_front());
      end
      h2c_0_valid = (h0_stim.size() != 0);
      if (h0_stim.size() != 0) begin
        h2c_0_beat = h0_stim[0];
      end
    end
  end

  initial begin : drive_h2c_1
    logic fire;
    h2c_1_valid = 1'b0;
    h2c_1_beat  = '0;
    forever begin
      @(posedge axis_aclk);
      fire = h2c_1_valid && h2c_1_ready;
      #1;
      if (fire) begin
        void'(h1_stim.pop_front());
      end
      h2c_1_valid = (h1_stim.size() != 0);
      if (h1_stim.size() != 0) begin
        h2c_1_beat = h1_stim[0];
      end
    end
  end

  initial begin : drive_nf_rx
    logic fire;
    nf_rx_valid = 1'b0;
    nf_rx_beat  = '0;
    forever begin
      @(posedge axis_aclk);
      fire = nf_rx_valid && nf_rx_ready;
      #1;
      if (fire) begin
        void'(rx_stim.pop_front());
      end
      nf_rx_valid = (rx_stim.size() != 0);
      if (rx_stim.size() != 0) begin
        nf_rx_beat = rx_stim[0];
      end
    end
  end

  // each output is ready about three cycles in four
  initial begin : drive_ready
    nf_tx_ready = 1'b0;
    c2h_0_ready = 1'b0;
    c2h_1_ready = 1'b0;
    forever begin
      @(posedge axis_aclk);
      #1;
      rdy_rng = xorshift32(rdy_rng);
      nf_tx_ready = (rdy_rng[9:8] != 2'b00);
      c2h_0_ready = (rdy_rng[17:16] != 2'b00);
      c2h_1_ready = (rdy_rng[25:24] != 2'b00);
    end
  end

  always @(posedge axis_aclk) begin
    if (axis_rst) begin
      rst_seen <= 1'b1;
    end
  end

  a_reset_quiet: assert property (@(posedge axis_aclk)
    $fell(axis_rst) |-> !nf_tx_valid && !c2h_0_valid && !c2h_1_valid)
    else begin
      errors++;
      $display("ERROR after_reset: an output valid was high right after reset");
    end

  a_ready_in_reset: assert property (@(posedge axis_aclk)
    rst_seen && axis_rst |-> !h2c_0_ready && !h2c_1_ready && !nf_rx_ready)
    else begin
      errors++;
      $display("ERROR after_reset: an input ready was high during reset");
    end

  // stalled outputs hold valid and the beat
  a_tx_hold: assert property (@(posedge axis_aclk) disable iff (axis_rst)
    nf_tx_valid && !nf_tx_ready |=> nf_tx_valid && $stable(nf_tx_beat))
    else begin
      errors++;
      $display("ERROR %s: nf_tx beat changed or dropped while stalled", test_name);
    end

  a_c2h0_hold: assert property (@(posedge axis_aclk) disable iff (axis_rst)
    c2h_0_valid && !c2h_0_ready |=> c2h_0_valid && $stable(c2h_0_beat))
    else begin
      errors++;
      $display("ERROR %s: c2h_0 beat changed or dropped while stalled", test_name);
    end

  a_c2h1_hold: assert property (@(posedge axis_aclk) disable iff (axis_rst)
    c2h_1_valid && !c2h_1_ready |=> c2h_1_valid && $stable(c2h_1_beat))
    else begin
      errors++;
      $display("ERROR %s: c2h_1 beat changed or dropped while stalled", test_name);
    end

  always @(posedge axis_aclk) begin
    if (!axis_rst && nf_tx_valid && nf_tx_ready) begin
      if (exp_tx.size() == 0) begin
        errors++;
        $display("ERROR %s: nf_tx delivered a beat that was never sent", test_name);
      end else begin
        exp_tx_beat = exp_tx.pop_front();
        a_tx_beat: assert (nf_tx_beat == exp_tx_beat) else begin
          errors++;
          $display("CHECK FAILED %s: nf_tx expected %h actual %h",
                   test_name, exp_tx_beat, nf_tx_beat);
        end
      end
    end
  end

  always @(posedge axis_aclk) begin
    if (!axis_rst && c2h_0_valid && c2h_0_ready) begin
      if (exp_c2h0.size() == 0) begin
        errors++;
        $display("ERROR %s: c2h_0 delivered a beat no packet addressed to it", test_name);
      end else begin
        exp_c2h0_beat = exp_c2h0.pop_front();
        a_c2h0_beat: assert (c2h_0_beat == exp_c2h0_beat) else begin
          errors++;
          $display("CHECK FAILED %s: c2h_0 expected %h actual %h",
                   test_name, exp_c2h0_beat, c2h_0_beat);
        end
      end
    end
  end

  always @(posedge axis_aclk) begin
    if (!axis_rst && c2h_1_valid && c2h_1_ready) begin
      if (exp_c2h1.size() == 0) begin
        errors++;
        $display("ERROR %s: c2h_1 delivered a beat no packet addressed to it", test_name);
      end else begin
        exp_c2h1_beat = exp_c2h1.pop_front();
        a_c2h1_beat: assert (c2h_1_beat == exp_c2h1_beat) else begin
          errors++;
          $display("CHECK FAILED %s: c2h_1 expected %h actual %h",
                   test_name, exp_c2h1_beat, c2h_1_beat);
        end
      end
    end
  end

  // limit grows as packets are scheduled
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= sched_beats * 8 + 200) begin
      @(posedge axis_aclk);
      cycles++;
    end
    $display("ERROR %s: timeout after %0d cycles, traffic did not drain", test_name, cycles);
    $display("tb_dma_attach: %0d errors before timeout", errors);
    $display("Verification failed");
    $finish;
  end

  initial begin : main_seq
    axis_rst = 1'b1;
    repeat (2) @(posedge axis_aclk);
    #1;
    axis_rst = 1'b0;
    @(posedge axis_aclk);
    test_name = "h2c_tagging";
    for (int i = 0; i < 6; i++) queue_h2c_packet(1'b0, rand_beats());
    wait_drain();
    for (int i = 0; i < 6; i++) queue_h2c_packet(1'b1, rand_beats());
    wait_drain();
    // queue 1 went last, so queue 0 opens the alternation
    test_name = "h2c_arbitration";
    for (int i = 0; i < 8; i++) begin
      queue_h2c_packet(1'b0, rand_beats());
      queue_h2c_packet(1'b1, rand_beats());
    end
    wait_drain();
    test_name = "c2h_steer";
    for (int i = 0; i < 5; i++) queue_rx_packet(8'h02, rand_beats());
    for (int i = 0; i < 5; i++) queue_rx_packet(8'h08, rand_beats());
    wait_drain();
    test_name = "c2h_broadcast";
    for (int i = 0; i < 6; i++) queue_rx_packet(8'h0a, rand_beats());
    wait_drain();
    test_name = "c2h_drop";
    queue_rx_packet(8'h00, 3);
    queue_rx_packet(8'h02, rand_beats());
    queue_rx_packet(8'hf5, 4);
    queue_rx_packet(8'h08, rand_beats());
    wait_drain();
    test_name = "backpressure_mixed";
    for (int i = 0; i < 10; i++) begin
      queue_h2c_packet(1'b0, rand_beats());
      queue_h2c_packet(1'b1, rand_beats());
      queue_rx_packet(dst_list[int'(draw_word() % 32'd5)], rand_beats());
    end
    wait_drain();
    repeat (20) @(posedge axis_aclk);
    $display("tb_dma_attach: %0d errors over %0d scheduled beats", errors, sched_beats);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/dma_attach_top.sv
/*
  DMA side of the host attachment, single clock domain.
  H2C: two host queues merged by packet, then a skid buffer to nf_tx.
  C2H: nf_rx through a skid buffer, then steered to the two host queues.
*/
`timescale 1ns/1ps
`default_nettype none

module dma_attach_top import dma_attach_pkg::*; (
  input  logic      axis_aclk,
  input  logic      axis_rst,
  input  h2c_beat_t h2c_0_beat,
  input  logic      h2c_0_valid,
  output logic      h2c_0_ready,
  input  h2c_beat_t h2c_1_beat,
  input  logic      h2c_1_valid,
  output logic      h2c_1_ready,
  output nf_beat_t  nf_tx_beat,
  output logic      nf_tx_valid,
  input  logic      nf_tx_ready,
  input  nf_beat_t  nf_rx_beat,
  input  logic      nf_rx_valid,
  output logic      nf_rx_ready,
  output c2h_beat_t c2h_0_beat,
  output logic      c2h_0_valid,
  input  logic      c2h_0_ready,
  output c2h_beat_t c2h_1_beat,
  output logic      c2h_1_valid,
  input  logic      c2h_1_ready
);

  // merged host traffic before the output slice
  nf_beat_t arb_beat;
  logic     arb_valid;
  logic     arb_ready;

  // card traffic after the input slice
  nf_beat_t rx_beat;
  logic     rx_valid;
  logic     rx_ready;

  h2c_queue_arbiter u_h2c_arb (
    .axis_aclk (axis_aclk),
    .axis_rst  (axis_rst),
    .q0_beat   (h2c_0_beat),
    .q0_valid  (h2c_0_valid),
    .q0_ready  (h2c_0_ready),
    .q1_beat   (h2c_1_beat),
    .q1_valid  (h2c_1_valid),
    .q1_ready  (h2c_1_ready),
    .out_beat  (arb_beat),
    .out_valid (arb_valid),
    .out_ready (arb_ready)
  );

  axis_skid_buffer u_h2c_skid (
    .axis_aclk (axis_aclk),
    .axis_rst  (axis_rst),
    .in_beat   (arb_beat),
    .in_valid  (arb_valid),
    .in_ready  (arb_ready),
    .out_beat  (nf_tx_beat),
    .out_valid (nf_tx_valid),
    .out_ready (nf_tx_ready)
  );

  axis_skid_buffer u_c2h_skid (
    .axis_aclk (axis_aclk),
    .axis_rst  (axis_rst),
    .in_beat   (nf_rx_beat),
    .in_valid  (nf_rx_valid),
    .in_ready  (nf_rx_ready),
    .out_beat  (rx_beat),
    .out_valid (rx_valid),
    .out_ready (rx_ready)
  );

  c2h_port_steer u_c2h_steer (
    .axis_aclk (axis_aclk),
    .axis_rst  (axis_rst),
    .in_beat   (rx_beat),
    .in_valid  (rx_valid),
    .in_ready  (rx_ready),
    .q0_beat   (c2h_0_beat),
    .q0_valid  (c2h_0_valid),
    .q0_ready  (c2h_0_ready),
    .q1_beat   (c2h_1_beat),
    .q1_valid  (c2h_1_valid),
    .q1_ready  (c2h_1_ready)
  );

endmodule

`default_nettype wire

//--- hw/c2h_port_steer.sv
/*
  Steers the internal stream to the two card-to-host queues by dst_port.
  The mask, length and source are sampled from the first beat and held
  until tlast moves. Both bits set means broadcast, neither bit set means
  the packet is consumed and dropped at full rate.
*/
`timescale 1ns/1ps
`default_nettype none

module c2h_port_steer import dma_attach_pkg::*; (
  input  logic      axis_aclk,
  input  logic      axis_rst,
  input  nf_beat_t  in_beat,
  input  logic      in_valid,
  output logic      in_ready,
  output c2h_beat_t q0_beat,
  output logic      q0_valid,
  input  logic      q0_ready,
  output c2h_beat_t q1_beat,
  output logic      q1_valid,
  input  logic      q1_ready
);

  steer_state_t state;
  logic [1:0]   mask_q;
  pkt_len_t     len_q;
  port_mask_t   src_q;
  logic [1:0]   taken_q;
  logic [1:0]   in_mask;
  logic [1:0]   cur_mask;
  pkt_len_t     cur_len;
  port_mask_t   cur_src;
  logic [1:0]   q_valid;
  logic [1:0]   q_ready;
  logic [1:0]   done;
  logic         accept;
  c2h_beat_t    base_beat;

  assign in_mask[0] = |(in_beat.tuser.dst_port & QDMA0_PORT);
  assign in_mask[1] = |(in_beat.tuser.dst_port & QDMA1_PORT);

  // first beat steers itself, later beats use what it left behind
  assign cur_mask = (state == STEER_IDLE) ? in_mask : mask_q;
  assign cur_len  = (state == STEER_IDLE) ? in_beat.tuser.pkt_len : len_q;
  assign cur_src  = (state == STEER_IDLE) ? in_beat.tuser.src_port : src_q;

  assign q_ready  = {q1_ready, q0_ready};
  assign q_valid  = {2{in_valid}} & cur_mask & ~taken_q;
  assign q0_valid = q_valid[0];
  assign q1_valid = q_valid[1];

  // an output is done when unselected, already served, or taking it now
  assign done     = ~cur_mask | taken_q | q_ready;
  assign in_ready = &done;
  assign accept   = in_valid && in_ready;

  always_comb begin
    base_beat.tdata = in_beat.tdata;
    base_beat.tkeep = in_beat.tkeep;
    base_beat.tlast = in_beat.tlast;
    base_beat.size  = cur_len;
    base_beat.src   = queue_id_t'(cur_src);
    base_beat.dst   = '0;
    q0_beat         = base_beat;
    q0_beat.dst     = QDMA0_QID;
    q1_beat         = base_beat;
    q1_beat.dst     = QDMA1_QID;
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state   <= STEER_IDLE;
      taken_q <= 2'b00;
    end else begin
      if (accept) begin
        taken_q <= 2'b00;
        state   <= in_beat.tlast ? STEER_IDLE : STEER_PKT;
      end else begin
        // remember which outputs already hold the current beat
        taken_q <= taken_q | (q_valid & q_ready);
      end
    end
  end

  // per-packet sideband, loaded with the first beat
  always_ff @(posedge axis_aclk) begin
    if (accept && (state == STEER_IDLE)) begin
      mask_q <= in_mask;
      len_q  <= in_beat.tuser.pkt_len;
      src_q  <= in_beat.tuser.src_port;
    end
  end

  // an output never shows valid for a queue the packet does not address
  a_valid_in_mask: assert property (@(posedge axis_aclk) disable iff (axis_rst)
    (!q0_valid || ((state == STEER_PKT) ? mask_q[0] : in_beat.tuser.dst_port[1])) &&
    (!q1_valid || ((state == STEER_PKT) ? mask_q[1] : in_beat.tuser.dst_port[3])));

endmodule

`default_nettype wire

//--- hw/h2c_queue_arbiter.sv
/*
  Packet-level round-robin merge of the two host-to-card queues.
  A grant is taken in the cycle after a queue shows valid, so there is one
  idle cycle between packets. Sideband carries length and source port only,
  the destination and reserved fields are always zero.
*/
`timescale 1ns/1ps
`default_nettype none

module h2c_queue_arbiter import dma_attach_pkg::*; (
  input  logic      axis_aclk,
  input  logic      axis_rst,
  input  h2c_beat_t q0_beat,
  input  logic      q0_valid,
  output logic      q0_ready,
  input  h2c_beat_t q1_beat,
  input  logic      q1_valid,
  output logic      q1_ready,
  output nf_beat_t  out_beat,
  output logic      out_valid,
  input  logic      out_ready
);

  arb_state_t state;
  arb_state_t state_next;
  logic       last_q1;
  h2c_beat_t  sel_beat;
  logic       sel_valid;
  logic       eop;

  // granted queue drives the output, nothing is valid while idle
  assign sel_beat = (state == ARB_Q1) ? q1_beat : q0_beat;

  always_comb begin
    case (state)
      ARB_Q0:  sel_valid = q0_valid;
      ARB_Q1:  sel_valid = q1_valid;
      default: sel_valid = 1'b0;
    endcase
  end

  assign out_valid = sel_valid;
  assign q0_ready  = (state == ARB_Q0) && out_ready;
  assign q1_ready  = (state == ARB_Q1) && out_ready;
  assign eop       = sel_valid && out_ready && sel_beat.tlast;

  // tag the granted beat with its length and source port
  always_comb begin
    out_beat.tdata          = sel_beat.tdata;
    out_beat.tkeep          = sel_beat.tkeep;
    out_beat.tlast          = sel_beat.tlast;
    out_beat.tuser.pkt_len  = sel_beat.size;
    out_beat.tuser.src_port = (state == ARB_Q1) ? QDMA1_PORT : QDMA0_PORT;
    out_beat.tuser.dst_port = '0;
    out_beat.tuser.reserved = '0;
  end

  always_comb begin
    state_next = state;
    case (state)
      ARB_IDLE: begin
        // on a tie the queue that was not served last goes first
        if (q0_valid && (!q1_valid || last_q1)) begin
          state_next = ARB_Q0;
        end else if (q1_valid) begin
          state_next = ARB_Q1;
        end
      end
      ARB_Q0, ARB_Q1: begin
        if (eop) begin
          state_next = ARB_IDLE;
        end
      end
      default: state_next = ARB_IDLE;
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state   <= ARB_IDLE;
      // pretend queue 1 went last so queue 0 takes the first tie
      last_q1 <= 1'b1;
    end else begin
      state <= state_next;
      if (state_next == ARB_Q0) begin
        last_q1 <= 1'b0;
      end else if (state_next == ARB_Q1) begin
        last_q1 <= 1'b1;
      end
    end
  end

  // a grant is held from the first beat up to the tlast transfer
  a_grant_held: assert property (@(posedge axis_aclk) disable iff (axis_rst)
    out_valid && !(out_ready && out_beat.tlast) |=> $stable(out_beat.tuser.src_port));

endmodule

`default_nettype wire

//--- hw/axis_skid_buffer.sv
/*
  Two-entry register slice for the internal stream.
  in_ready is registered and falls only when both entries hold a beat.
  A beat taken in one cycle is presented at the output in the next.
*/
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer import dma_attach_pkg::*; (
  input  logic     axis_aclk,
  input  logic     axis_rst,
  input  nf_beat_t in_beat,
  input  logic     in_valid,
  output logic     in_ready,
  output nf_beat_t out_beat,
  output logic     out_valid,
  input  logic     out_ready
);

  nf_beat_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic [1:0] count_next;
  logic       push;
  logic       pop;

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_valid = (count != 2'd0);
  assign out_beat  = mem[rd_ptr];

  // occupancy after this cycle's push and pop
  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + 2'd1;
      2'b01:   count_next = count - 2'd1;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
      count    <= 2'd0;
      in_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count    <= count_next;
      // look ahead so ready is low in the cycle both entries are full
      in_ready <= (count_next != 2'd2);
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // a stalled output beat must be held until it is taken
  a_out_stable: assert property (@(posedge axis_aclk) disable iff (axis_rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

`default_nettype wire

//--- hw/dma_attach_pkg.sv
/*
  Shared widths, port codes and stream beat types for the DMA attachment.
  The data path is 64 bits wide. Port codes follow the internal one-hot
  sideband convention, where bit 1 is host queue 0 and bit 3 is host queue 1.
*/
`default_nettype none

package dma_attach_pkg;

  localparam int DATA_W = 64;
  localparam int KEEP_W = DATA_W / 8;
  localparam int RSVD_W = 96;

  typedef logic [DATA_W-1:0] tdata_t;
  typedef logic [KEEP_W-1:0] tkeep_t;
  typedef logic [15:0]       pkt_len_t;
  typedef logic [7:0]        port_mask_t;
  typedef logic [15:0]       queue_id_t;

  // one-hot internal port bits of the two host queues
  localparam port_mask_t QDMA0_PORT = 8'h02;
  localparam port_mask_t QDMA1_PORT = 8'h08;

  // destination codes presented to the host side
  localparam queue_id_t QDMA0_QID = 16'h1;
  localparam queue_id_t QDMA1_QID = 16'h2;

  // declared msb first, so pkt_len sits at [15:0] and dst_port at [31:24]
  typedef struct packed {
    logic [RSVD_W-1:0] reserved;
    port_mask_t        dst_port;
    port_mask_t        src_port;
    pkt_len_t          pkt_len;
  } nf_tuser_t;

  typedef struct packed {
    tdata_t    tdata;
    tkeep_t    tkeep;
    logic      tlast;
    nf_tuser_t tuser;
  } nf_beat_t;

  typedef struct packed {
    tdata_t   tdata;
    tkeep_t   tkeep;
    logic     tlast;
    pkt_len_t size;
  } h2c_beat_t;

  typedef struct packed {
    tdata_t    tdata;
    tkeep_t    tkeep;
    logic      tlast;
    pkt_len_t  size;
    queue_id_t src;
    queue_id_t dst;
  } c2h_beat_t;

  typedef enum logic [1:0] {ARB_IDLE, ARB_Q0, ARB_Q1} arb_state_t;

  typedef enum logic {STEER_IDLE, STEER_PKT} steer_state_t;

endpackage

`default_nettype wire
